//--- source/bcd_add_pkg.sv
`default_nettype none

// Shared widths, encodings and types of the decimal adder.
package bcd_add_pkg;

	//////////////////////////////
	// Widths.
	//////////////////////////////

	// Switch operand, tens digit on bits 6 to 4.
	localparam int operand_width = 7;
	// One decimal digit.
	localparam int digit_width = 4;
	// One segment pattern, g down to a, active high.
	localparam int seg_width = 7;
	// Phase counter and controller state.
	localparam int phase_width = 2;

	//////////////////////////////
	// Controller state codes.
	//////////////////////////////

	localparam logic [1:0] st_reset_init = 2'd0;
	localparam logic [1:0] st_idle = 2'd1;
	localparam logic [1:0] st_request = 2'd2;
	localparam logic [1:0] st_release = 2'd3;

	// One datapath operation per handshake.
	typedef enum logic [2:0]
	{
		op_init = 3'd0,
		op_load_a = 3'd1,
		op_load_b = 3'd2,
		op_show_low = 3'd3,
		op_show_high = 3'd4
	} dp_op_e;

	// Displayed word, as a raw byte or as two digits.
	typedef union packed
	{
		logic [2*digit_width-1:0] raw;
		struct packed
		{
			logic [digit_width-1:0] tens;
			logic [digit_width-1:0] ones;
		} digits;
	} bcd_pair_u;

endpackage

`default_nettype wire

//--- source/dp_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// Operation link between controller and datapath.
// Four-phase handshake, op held while req or ack is high.
interface dp_cmd_if;

	// Requested operation.
	bcd_add_pkg::dp_op_e op;
	// Level request from the controller.
	logic req;
	// Level acknowledge from the datapath.
	logic ack;
	// Word currently on the display.
	bcd_add_pkg::bcd_pair_u display_word;
	// Ones digit clamp of the last load.
	logic digit_error;

	modport controller
	(
		output op,
		output req,
		input  ack
	);

	modport datapath
	(
		input  op,
		input  req,
		output ack,
		output display_word,
		output digit_error
	);

endinterface

`default_nettype wire

//--- source/input_sampler.sv
`timescale 1ns/1ps
`default_nettype none

// Brings the switches and the step button into the clock domain.
module input_sampler
(
	input  wire                                 clock,
	input  wire                                 rst_n,
	input  wire  [bcd_add_pkg::operand_width-1:0] switches,
	input  wire                                 step,
	output logic [bcd_add_pkg::operand_width-1:0] sampled_value,
	output logic                                step_pulse
);

	// First stage of the switch synchronizer.
	logic [bcd_add_pkg::operand_width-1:0] switches_meta;
	// Button synchronizer and edge stage.
	logic step_meta;
	logic step_sync;
	logic step_last;

	// Two stages on the switches.
	always_ff @(posedge clock)
	begin
		switches_meta <= switches;
		sampled_value <= switches_meta;
	end

	// Button stages and the registered rising edge.
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			step_meta <= 1'b0;
			step_sync <= 1'b0;
			step_last <= 1'b0;
			step_pulse <= 1'b0;
		end
		else
		begin
			step_meta <= step;
			step_sync <= step_meta;
			step_last <= step_sync;
			// High for one cycle after the level rises.
			step_pulse <= step_sync & ~step_last;
		end
	end

endmodule

`default_nettype wire

//--- source/bcd_add_controller.sv
`timescale 1ns/1ps
`default_nettype none

// Phase FSM, one datapath operation per step press.
module bcd_add_controller
(
	input  wire                                 clock,
	input  wire                                 rst_n,
	input  wire                                 step_pulse,
	dp_cmd_if.controller                        cmd,
	output logic [bcd_add_pkg::phase_width-1:0] phase
);

	// Current FSM state.
	logic [1:0] state;
	// Phase that takes effect when the handshake completes.
	logic [bcd_add_pkg::phase_width-1:0] target_phase;
	// Phase that the next step moves to.
	logic [bcd_add_pkg::phase_width-1:0] next_phase;

	// Operation that belongs to each phase.
	function automatic bcd_add_pkg::dp_op_e phase_op
	(
		input logic [bcd_add_pkg::phase_width-1:0] new_phase
	);
		case (new_phase)
			2'd0:    phase_op = bcd_add_pkg::op_load_a;
			2'd1:    phase_op = bcd_add_pkg::op_load_b;
			2'd2:    phase_op = bcd_add_pkg::op_show_low;
			default: phase_op = bcd_add_pkg::op_show_high;
		endcase
	endfunction

	// Wraps from 3 back to 0.
	assign next_phase = phase + 2'd1;

	//////////////////////////////
	// Handshake FSM.
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			state <= bcd_add_pkg::st_reset_init;
			cmd.req <= 1'b0;
			cmd.op <= bcd_add_pkg::op_init;
			// Parked on phase 3, so the first step loads A.
			phase <= 2'd3;
			target_phase <= 2'd3;
		end
		else
		begin
			case (state)
				bcd_add_pkg::st_reset_init:
				begin
					// Single clear after reset.
					cmd.op <= bcd_add_pkg::op_init;
					cmd.req <= 1'b1;
					target_phase <= 2'd3;
					state <= bcd_add_pkg::st_request;
				end
				bcd_add_pkg::st_idle:
				begin
					// Steps outside idle are dropped.
					if (step_pulse)
					begin
						cmd.op <= phase_op(next_phase);
						cmd.req <= 1'b1;
						target_phase <= next_phase;
						state <= bcd_add_pkg::st_request;
					end
				end
				bcd_add_pkg::st_request:
				begin
					// Ack seen, drop req and show the new phase.
					if (cmd.ack)
					begin
						cmd.req <= 1'b0;
						phase <= target_phase;
						state <= bcd_add_pkg::st_release;
					end
				end
				default:
				begin
					// Wait for ack to fall.
					if (!cmd.ack)
						state <= bcd_add_pkg::st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/bcd_add_datapath.sv
`timescale 1ns/1ps
`default_nettype none

// Operand registers, decimal sum and display word.
module bcd_add_datapath
(
	input  wire                                   clock,
	input  wire                                   rst_n,
	input  wire  [bcd_add_pkg::operand_width-1:0] sampled_value,
	dp_cmd_if.datapath                            cmd
);

	// Stored operands as digits.
	logic [bcd_add_pkg::digit_width-1:0] a_tens;
	logic [bcd_add_pkg::digit_width-1:0] a_ones;
	logic [bcd_add_pkg::digit_width-1:0] b_tens;
	logic [bcd_add_pkg::digit_width-1:0] b_ones;
	// Switch value split into digits.
	logic [bcd_add_pkg::digit_width-1:0] in_tens;
	logic [bcd_add_pkg::digit_width-1:0] in_ones;
	logic in_clamped;
	// Sum stages.
	logic [bcd_add_pkg::digit_width:0] ones_raw;
	logic [bcd_add_pkg::digit_width:0] tens_raw;
	logic ones_carry;
	logic tens_carry;
	logic [bcd_add_pkg::digit_width-1:0] sum_ones;
	logic [bcd_add_pkg::digit_width-1:0] sum_tens;
	// New request, not yet acknowledged.
	logic op_fire;

	assign op_fire = cmd.req & ~cmd.ack;

	// Tens digit is 0 to 7, ones digit clamped to 9.
	always_comb
	begin
		in_tens = {1'b0, sampled_value[bcd_add_pkg::operand_width-1:bcd_add_pkg::digit_width]};
		in_clamped = sampled_value[bcd_add_pkg::digit_width-1:0] > 4'd9;
		in_ones = in_clamped ? 4'd9 : sampled_value[bcd_add_pkg::digit_width-1:0];
	end

	//////////////////////////////
	// Decimal sum.
	//////////////////////////////

	always_comb
	begin
		ones_raw = {1'b0, a_ones} + {1'b0, b_ones};
		ones_carry = ones_raw > 5'd9;
		// Add 6 to skip the unused codes, carry goes to tens.
		sum_ones = ones_carry ? ones_raw[3:0] + 4'd6 : ones_raw[3:0];
		tens_raw = {1'b0, a_tens} + {1'b0, b_tens} + {4'd0, ones_carry};
		tens_carry = tens_raw > 5'd9;
		// Largest sum is 158, so hundreds is 0 or 1.
		sum_tens = tens_carry ? tens_raw[3:0] - 4'd10 : tens_raw[3:0];
	end

	// Operand capture.
	always_ff @(posedge clock)
	begin
		if (op_fire)
		begin
			case (cmd.op)
				bcd_add_pkg::op_init:
				begin
					a_tens <= '0;
					a_ones <= '0;
					b_tens <= '0;
					b_ones <= '0;
				end
				bcd_add_pkg::op_load_a:
				begin
					a_tens <= in_tens;
					a_ones <= in_ones;
				end
				bcd_add_pkg::op_load_b:
				begin
					b_tens <= in_tens;
					b_ones <= in_ones;
				end
				default:
				begin
				end
			endcase
		end
	end

	// Acknowledge and display update.
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			cmd.ack <= 1'b0;
			cmd.display_word <= '0;
			cmd.digit_error <= 1'b0;
		end
		else if (op_fire)
		begin
			cmd.ack <= 1'b1;
			case (cmd.op)
				bcd_add_pkg::op_load_a, bcd_add_pkg::op_load_b:
				begin
					cmd.display_word.digits.tens <= in_tens;
					cmd.display_word.digits.ones <= in_ones;
					cmd.digit_error <= in_clamped;
				end
				bcd_add_pkg::op_show_low:
				begin
					cmd.display_word.digits.tens <= sum_tens;
					cmd.display_word.digits.ones <= sum_ones;
				end
				bcd_add_pkg::op_show_high:
				begin
					cmd.display_word.digits.tens <= 4'd0;
					cmd.display_word.digits.ones <= {3'd0, tens_carry};
				end
				default:
				begin
					cmd.display_word <= '0;
					cmd.digit_error <= 1'b0;
				end
			endcase
		end
		else if (!cmd.req && cmd.ack)
			// Req released, close the handshake.
			cmd.ack <= 1'b0;
	end

endmodule

`default_nettype wire

//--- source/seven_seg_display.sv
`timescale 1ns/1ps
`default_nettype none

// Registered digit to segment decode for two digits.
module seven_seg_display
(
	input  wire                                clock,
	input  wire                                rst_n,
	input  wire  bcd_add_pkg::bcd_pair_u       display_word,
	output logic [bcd_add_pkg::seg_width-1:0]  seg_tens,
	output logic [bcd_add_pkg::seg_width-1:0]  seg_ones
);

	// Segments g down to a, blank above 9.
	function automatic logic [bcd_add_pkg::seg_width-1:0] digit_segments
	(
		input logic [bcd_add_pkg::digit_width-1:0] digit
	);
		case (digit)
			4'd0:    digit_segments = 7'h3f;
			4'd1:    digit_segments = 7'h06;
			4'd2:    digit_segments = 7'h5b;
			4'd3:    digit_segments = 7'h4f;
			4'd4:    digit_segments = 7'h66;
			4'd5:    digit_segments = 7'h6d;
			4'd6:    digit_segments = 7'h7d;
			4'd7:    digit_segments = 7'h07;
			4'd8:    digit_segments = 7'h7f;
			4'd9:    digit_segments = 7'h6f;
			default: digit_segments = 7'h00;
		endcase
	endfunction

	// One cycle behind the display word.
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			seg_tens <= '0;
			seg_ones <= '0;
		end
		else
		begin
			seg_tens <= digit_segments(display_word.digits.tens);
			seg_ones <= digit_segments(display_word.digits.ones);
		end
	end

endmodule

`default_nettype wire

//--- source/bcd_adder_top.sv
`timescale 1ns/1ps
`default_nettype none

// Two-digit decimal adder, board level.
module bcd_adder_top
(
	input  wire                                  clock,
	input  wire                                  rst_n,
	input  wire  [bcd_add_pkg::operand_width-1:0] switches,
	input  wire                                  step,
	output logic [2*bcd_add_pkg::digit_width-1:0] display_value,
	output logic [bcd_add_pkg::seg_width-1:0]    seg_tens,
	output logic [bcd_add_pkg::seg_width-1:0]    seg_ones,
	output logic                                 digit_error,
	output logic [bcd_add_pkg::phase_width-1:0]  phase
);

	// Synchronized operand and step pulse.
	logic [bcd_add_pkg::operand_width-1:0] sampled_value;
	logic step_pulse;

	// Controller to datapath link.
	dp_cmd_if cmd_link();

	input_sampler i_sampler
	(
		.clock         (clock),
		.rst_n         (rst_n),
		.switches      (switches),
		.step          (step),
		.sampled_value (sampled_value),
		.step_pulse    (step_pulse)
	);

	bcd_add_controller i_controller
	(
		.clock      (clock),
		.rst_n      (rst_n),
		.step_pulse (step_pulse),
		.cmd        (cmd_link.controller),
		.phase      (phase)
	);

	bcd_add_datapath i_datapath
	(
		.clock         (clock),
		.rst_n         (rst_n),
		.sampled_value (sampled_value),
		.cmd           (cmd_link.datapath)
	);

	seven_seg_display i_display
	(
		.clock        (clock),
		.rst_n        (rst_n),
		.display_word (cmd_link.display_word),
		.seg_tens     (seg_tens),
		.seg_ones     (seg_ones)
	);

	// Raw byte view and flag at the pins.
	assign display_value = cmd_link.display_word.raw;
	assign digit_error = cmd_link.digit_error;

endmodule

`default_nettype wire

//--- sim/bcd_adder_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// Request and acknowledge protocol checks.
module bcd_adder_assertions
(
	input wire                       clock,
	input wire                       rst_n,
	input wire                       req,
	input wire                       ack,
	input wire bcd_add_pkg::dp_op_e  op
);

	// Ack only answers a live request.
	ack_needs_req: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(ack) |-> req)
		else $error("ack rose while req was low");

	// Operation held for the whole request.
	op_held: assert property (@(posedge clock) disable iff (!rst_n)
		(req && $past(req)) |-> $stable(op))
		else $error("op changed while req was high");

	// Req drops only once acknowledged.
	req_after_ack: assert property (@(posedge clock) disable iff (!rst_n)
		$fell(req) |-> $past(ack))
		else $error("req fell before ack");

	// Ack closes within 2 cycles of req.
	ack_release: assert property (@(posedge clock) disable iff (!rst_n)
		ack |-> (req || $past(req) || $past(req, 2)))
		else $error("ack stayed high after req fell");

endmodule

bind bcd_add_datapath bcd_adder_assertions i_assertions
(
	.clock (clock),
	.rst_n (rst_n),
	.req   (cmd.req),
	.ack   (cmd.ack),
	.op    (cmd.op)
);

`default_nettype wire

//--- sim/bcd_adder_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the two-digit decimal adder.
module bcd_adder_tb;

	// Cycles allowed for one phase change.
	localparam int wait_limit = 20;
	// Segments g down to a for digits 0 to 9.
	localparam logic [bcd_add_pkg::seg_width-1:0] seg_ref [0:9] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07, 7'h7f, 7'h6f};

	logic clock;
	logic rst_n;
	logic [bcd_add_pkg::operand_width-1:0] switches;
	logic step;
	logic [2*bcd_add_pkg::digit_width-1:0] display_value;
	logic [bcd_add_pkg::seg_width-1:0] seg_tens;
	logic [bcd_add_pkg::seg_width-1:0] seg_ones;
	logic digit_error;
	logic [bcd_add_pkg::phase_width-1:0] phase;

	// LCG state.
	logic [31:0] rand_state;
	// Run bookkeeping.
	int error_count;
	int check_count;
	int test_count;
	int errors_at_start;

	bcd_adder_top i_dut
	(
		.clock         (clock),
		.rst_n         (rst_n),
		.switches      (switches),
		.step          (step),
		.display_value (display_value),
		.seg_tens      (seg_tens),
		.seg_ones      (seg_ones),
		.digit_error   (digit_error),
		.phase         (phase)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////
	// Model.
	//////////////////////////////

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// Operand as a number with the ones digit clamped to 9.
	function automatic int clamped_value(input logic [bcd_add_pkg::operand_width-1:0] sw);
		int ones;
		ones = int'(sw[3:0]);
		if (ones > 9)
			ones = 9;
		return int'(sw[6:4]) * 10 + ones;
	endfunction

	// Low two decimal digits of a number.
	function automatic bcd_add_pkg::bcd_pair_u decimal_word(input int value);
		bcd_add_pkg::bcd_pair_u word;
		word.digits.tens = 4'((value / 10) % 10);
		word.digits.ones = 4'(value % 10);
		return word;
	endfunction

	// Blank above 9.
	function automatic logic [bcd_add_pkg::seg_width-1:0] expected_segments
	(
		input logic [bcd_add_pkg::digit_width-1:0] digit
	);
		if (digit > 4'd9)
			return '0;
		return seg_ref[digit];
	endfunction

	//////////////////////////////
	// Compare tasks.
	//////////////////////////////

	task automatic check_word(input string name, input bcd_add_pkg::bcd_pair_u got,
		input bcd_add_pkg::bcd_pair_u exp);
		check_count++;
		if (got.raw !== exp.raw)
		begin
			$display("** Error: %s got %h expected %h", name, got.raw, exp.raw);
			error_count++;
		end
	endtask

	task automatic check_segments(input logic [bcd_add_pkg::seg_width-1:0] got_tens,
		input logic [bcd_add_pkg::seg_width-1:0] got_ones,
		input logic [bcd_add_pkg::seg_width-1:0] exp_tens,
		input logic [bcd_add_pkg::seg_width-1:0] exp_ones);
		check_count++;
		if (got_tens !== exp_tens)
		begin
			$display("** Error: seg_tens got %h expected %h", got_tens, exp_tens);
			error_count++;
		end
		if (got_ones !== exp_ones)
		begin
			$display("** Error: seg_ones got %h expected %h", got_ones, exp_ones);
			error_count++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp);
		check_count++;
		if (got !== exp)
		begin
			$display("** Error: digit_error got %h expected %h", got, exp);
			error_count++;
		end
	endtask

	task automatic check_phase(input logic [bcd_add_pkg::phase_width-1:0] exp);
		check_count++;
		if (phase !== exp)
		begin
			$display("** Error: phase got %h expected %h", phase, exp);
			error_count++;
		end
	endtask

	task automatic report_test(input string name);
		test_count++;
		$display("Test %0d %s done, %0d errors", test_count, name,
			error_count - errors_at_start);
		errors_at_start = error_count;
	endtask

	// Closing counts and verdict.
	task automatic finish_run();
		$display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	endtask

	//////////////////////////////
	// Stimulus.
	//////////////////////////////

	task automatic apply_switches(input logic [bcd_add_pkg::operand_width-1:0] sw);
		@(posedge clock);
		switches <= sw;
	endtask

	// One press and an optional second press inside the handshake.
	task automatic step_and_check(input logic [bcd_add_pkg::phase_width-1:0] exp_phase,
		input bcd_add_pkg::bcd_pair_u exp_word, input logic exp_flag,
		input logic double_press);
		logic [bcd_add_pkg::phase_width-1:0] start_phase;
		bcd_add_pkg::bcd_pair_u early_word;
		bcd_add_pkg::bcd_pair_u shown;
		int cycles;
		logic changed;
		start_phase = phase;
		early_word.raw = '0;
		cycles = 0;
		changed = 1'b0;
		@(posedge clock);
		step <= 1'b1;
		while (!changed)
		begin
			@(posedge clock);
			cycles++;
			if (cycles == 3)
				step <= 1'b0;
			// Second rising edge while req is still high.
			if (double_press && cycles == 4)
				step <= 1'b1;
			@(negedge clock);
			// Cycle 5 is 4 cycles after the step edge.
			if (cycles == 5)
				early_word.raw = display_value;
			changed = (phase != start_phase);
			if (!changed && cycles >= wait_limit)
			begin
				$display("Timeout, phase did not change within %0d cycles", wait_limit);
				error_count++;
				finish_run();
			end
		end
		if (cycles != 6)
		begin
			$display("Phase changed %0d cycles after the step edge instead of 5", cycles - 1);
			error_count++;
		end
		check_phase(exp_phase);
		check_word("display_value", early_word, exp_word);
		shown.raw = display_value;
		check_word("display_value", shown, exp_word);
		check_segments(seg_tens, seg_ones, expected_segments(exp_word.digits.tens),
			expected_segments(exp_word.digits.ones));
		check_flag(digit_error, exp_flag);
		// Phase must hold while the button is released.
		for (int i = 0; i < 12; i++)
		begin
			@(posedge clock);
			step <= 1'b0;
			@(negedge clock);
			if (phase != exp_phase)
			begin
				$display("Phase moved again without a new step press");
				error_count++;
			end
		end
	endtask

	// Load A, load B, show both halves of the sum.
	task automatic run_pair(input logic [bcd_add_pkg::operand_width-1:0] sw_a,
		input logic [bcd_add_pkg::operand_width-1:0] sw_b, input logic double_first);
		int a;
		int b;
		logic flag_b;
		a = clamped_value(sw_a);
		b = clamped_value(sw_b);
		flag_b = sw_b[3:0] > 4'd9;
		apply_switches(sw_a);
		step_and_check(2'd0, decimal_word(a), sw_a[3:0] > 4'd9, double_first);
		apply_switches(sw_b);
		step_and_check(2'd1, decimal_word(b), flag_b, 1'b0);
		// Show operations keep the flag of the last load.
		step_and_check(2'd2, decimal_word((a + b) % 100), flag_b, 1'b0);
		step_and_check(2'd3, decimal_word((a + b) / 100), flag_b, 1'b0);
	endtask

	//////////////////////////////
	// Test sequence.
	//////////////////////////////

	initial
	begin
		logic [31:0] r;
		logic [bcd_add_pkg::operand_width-1:0] sw_a;
		logic [bcd_add_pkg::operand_width-1:0] sw_b;
		int ones_carries;
		int hundreds;
		rst_n = 1'b0;
		step = 1'b0;
		switches = '0;
		rand_state = 32'h914c_1bf4;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		errors_at_start = 0;
		ones_carries = 0;
		hundreds = 0;
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;
		// Clear operation runs once after reset.
		repeat (10) @(posedge clock);
		@(negedge clock);
		check_word("display_value", bcd_add_pkg::bcd_pair_u'(display_value), decimal_word(0));
		check_flag(digit_error, 1'b0);
		check_phase(2'd3);
		report_test("reset state");

		// 45 + 38 with a carry out of the ones.
		run_pair(7'h45, 7'h38, 1'b0);
		report_test("load order");

		for (int n = 0; n < 100; n++)
		begin
			r = next_random();
			sw_a = r[6:0];
			sw_b = r[14:8];
			if (clamped_value(sw_a) % 10 + clamped_value(sw_b) % 10 > 9)
				ones_carries++;
			if (clamped_value(sw_a) + clamped_value(sw_b) > 99)
				hundreds++;
			run_pair(sw_a, sw_b, 1'b0);
		end
		if (ones_carries == 0 || hundreds == 0)
		begin
			$display("Random pairs missed a ones carry or a hundreds carry");
			error_count++;
		end
		report_test("random sums");

		// Ones digit 10 to 15 on A and a valid B that clears the flag.
		for (int n = 0; n < 6; n++)
		begin
			r = next_random();
			sw_a = {r[22:20], 4'(10 + n)};
			sw_b = {r[26:24], 4'(int'(r[15:0]) % 10)};
			run_pair(sw_a, sw_b, 1'b0);
		end
		report_test("digit clamp");

		// Every digit 0 to 9 on the ones display.
		for (int d = 0; d < 8; d++)
			run_pair({3'(d), 4'(d)}, {3'(7 - d), 4'(9 - d)}, 1'b0);
		report_test("segment decode");

		r = next_random();
		run_pair(r[6:0], r[14:8], 1'b1);
		report_test("step during handshake");

		finish_run();
	end

endmodule

`default_nettype wire

//--- sim.f
source/bcd_add_pkg.sv
source/dp_cmd_if.sv
source/input_sampler.sv
source/bcd_add_controller.sv
source/bcd_add_datapath.sv
source/seven_seg_display.sv
source/bcd_adder_top.sv
sim/bcd_adder_assertions.sv
sim/bcd_adder_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= bcd_adder_tb
FILE_LIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG_FILE ?= sim.log
PASS_TEXT ?= STATUS: PASS
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG_FILE)
	grep -qx "$(PASS_TEXT)" $(LOG_FILE)

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)
